//--- src.f
+incdir+.
soc_pkg.sv
mem_map_decoder.sv
dual_port_ram.sv
dbg_apb_requester.sv
dbg_apb_arbiter.sv
core_bus_fabric.sv
tb_core_bus_fabric.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
# Exit status is nonzero when the build fails or the testbench stops with $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_core_bus_fabric -f src.f \
  --Mdir obj_dir -o tb_core_bus_fabric &&
./obj_dir/tb_core_bus_fabric ||
{ echo "Simulation build or run failed"; exit 1; }

//--- tb_core_bus_fabric.sv
// ================================================
// Table-driven testbench for the core bus fabric
// with an APB slave model and core-side drivers
// ================================================
`timescale 1ns/100ps

`include "soc_defines.svh"

module tb_core_bus_fabric;

  localparam int CLK_PERIOD     = 40;
  // Sample point sits just before the rising edge
  localparam int SAMPLE_DLY     = 18;
  localparam int TIMEOUT_CYCLES = 40;

  // Port and operation codes of the stimulus table
  localparam logic [1:0] PORT_FETCH = 2'd0;
  localparam logic [1:0] PORT_DATA  = 2'd1;
  localparam logic [1:0] PORT_BOTH  = 2'd2;
  localparam logic       OP_READ    = 1'b0;
  localparam logic       OP_WRITE   = 1'b1;

  // For PORT_BOTH the wdata field holds the data-side address
  typedef struct packed {
    logic [1:0]  port;
    logic        op;
    logic        dbg;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
  } entry_t;

  logic               clk;
  logic               reset_n;
  logic               i_debug_mode;
  logic [31:0]        i_imem_addr;
  logic               i_imem_rready;
  logic               o_imem_rvalid;
  logic [31:0]        o_imem_rdata;
  logic [31:0]        i_dmem_addr;
  logic               i_dmem_rready;
  logic               i_dmem_wvalid;
  logic [31:0]        i_dmem_wdata;
  logic               o_dmem_rvalid;
  logic               o_dmem_wready;
  logic [31:0]        o_dmem_rdata;
  logic [`DBG_AW-1:0] o_dbg_paddr;
  logic               o_dbg_psel;
  logic               o_dbg_penable;
  logic               o_dbg_pwrite;
  logic [31:0]        o_dbg_pwdata;
  logic               i_dbg_pready;
  logic [31:0]        i_dbg_prdata;
  logic [31:0]        o_tohost;

  // APB slave storage, word index from paddr[11:2]
  logic [31:0] slave_mem [0:1023];
  integer      seed;
  int          xfer_count;
  entry_t      stim_q [$];

  core_bus_fabric core_bus_fabric_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_imem_addr   (i_imem_addr),
    .i_imem_rready (i_imem_rready),
    .o_imem_rvalid (o_imem_rvalid),
    .o_imem_rdata  (o_imem_rdata),
    .i_dmem_addr   (i_dmem_addr),
    .i_dmem_rready (i_dmem_rready),
    .i_dmem_wvalid (i_dmem_wvalid),
    .i_dmem_wdata  (i_dmem_wdata),
    .o_dmem_rvalid (o_dmem_rvalid),
    .o_dmem_wready (o_dmem_wready),
    .o_dmem_rdata  (o_dmem_rdata),
    .o_dbg_paddr   (o_dbg_paddr),
    .o_dbg_psel    (o_dbg_psel),
    .o_dbg_penable (o_dbg_penable),
    .o_dbg_pwrite  (o_dbg_pwrite),
    .o_dbg_pwdata  (o_dbg_pwdata),
    .i_dbg_pready  (i_dbg_pready),
    .i_dbg_prdata  (i_dbg_prdata),
    .o_tohost      (o_tohost)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
    if (got !== exp_val)
    begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp_val);
      $display("TESTS FAILED");
      $fatal(1, "Value check on %s", name);
    end
  endtask

  task automatic fail_run(input string why);
    $display("Error: %s", why);
    $display("TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic add_entry(input logic [1:0] port, input logic op, input logic dbg,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp_data);
    entry_t e;
    e.port     = port;
    e.op       = op;
    e.dbg      = dbg;
    e.addr     = addr;
    e.wdata    = wdata;
    e.exp_data = exp_data;
    stim_q.push_back(e);
  endtask

  // ================================================
  // Core-side drivers
  // ================================================
  // Holds rready until rvalid, counts sample points before it
  task automatic read_port(input logic [1:0] port, input logic [31:0] addr,
                           output logic [31:0] data, output int cycles);
    logic valid;
    cycles = 0;
    valid  = 1'b0;
    @(negedge clk);
    if (port == PORT_FETCH)
    begin
      i_imem_addr   = addr;
      i_imem_rready = 1'b1;
    end
    else
    begin
      i_dmem_addr   = addr;
      i_dmem_rready = 1'b1;
    end
    while (!valid)
    begin
      #(SAMPLE_DLY);
      valid = (port == PORT_FETCH) ? o_imem_rvalid : o_dmem_rvalid;
      data  = (port == PORT_FETCH) ? o_imem_rdata : o_dmem_rdata;
      if (!valid)
      begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
          fail_run("read valid never arrived");
        @(negedge clk);
      end
    end
    @(negedge clk);
    if (port == PORT_FETCH)
      i_imem_rready = 1'b0;
    else
      i_dmem_rready = 1'b0;
    // Read word must stay put once the valid pulse is over
    #(SAMPLE_DLY);
    if (port == PORT_FETCH)
      check_value("o_imem_rdata", o_imem_rdata, data);
    else
      check_value("o_dmem_rdata", o_dmem_rdata, data);
  endtask

  // Holds wvalid until wready; tohost has no responder, one cycle only
  task automatic write_data(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic dbg_hit, output int cycles);
    logic ready;
    cycles = 0;
    ready  = 1'b0;
    @(negedge clk);
    i_dmem_addr   = addr;
    i_dmem_wdata  = wdata;
    i_dmem_wvalid = 1'b1;
    while (!ready && (addr != `TOHOST_ADDR))
    begin
      #(SAMPLE_DLY);
      ready = o_dmem_wready;
      if (ready && dbg_hit)
      begin
        // Debug store may only complete together with pready
        check_value("o_dbg_penable", 32'(o_dbg_penable), 32'd1);
        check_value("i_dbg_pready", 32'(i_dbg_pready), 32'd1);
      end
      else if (!ready)
      begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
          fail_run("write ready never arrived");
        @(negedge clk);
      end
    end
    @(negedge clk);
    i_dmem_wvalid = 1'b0;
  endtask

  // ================================================
  // APB slave model
  // ================================================
  // Random 0-3 wait states, setup must last exactly one cycle
  initial
  begin : apb_slave_model
    int   wait_cnt;
    logic in_setup;
    wait_cnt     = 0;
    in_setup     = 1'b0;
    xfer_count   = 0;
    i_dbg_pready = 1'b0;
    i_dbg_prdata = '0;
    seed         = 37247;
    for (int i = 0; i < 1024; i++)
      slave_mem[i] = $random(seed);
    forever
    begin
      @(negedge clk);
      i_dbg_pready = 1'b0;
      if (o_dbg_penable && !o_dbg_psel)
        fail_run("APB penable high without psel");
      if (o_dbg_psel && o_dbg_penable)
      begin
        in_setup = 1'b0;
        if (wait_cnt == 0)
        begin
          i_dbg_pready = 1'b1;
          i_dbg_prdata = slave_mem[o_dbg_paddr[11:2]];
          if (o_dbg_pwrite)
            slave_mem[o_dbg_paddr[11:2]] = o_dbg_pwdata;
          xfer_count = xfer_count + 1;
        end
        else
          wait_cnt = wait_cnt - 1;
      end
      else if (o_dbg_psel)
      begin
        if (in_setup)
          fail_run("APB setup phase lasted more than one cycle");
        in_setup = 1'b1;
        wait_cnt = $random(seed) & 3;
      end
      else if (in_setup)
        fail_run("APB setup phase not followed by access");
    end
  end

  // ================================================
  // Stimulus table and main sequence
  // ================================================
  task automatic build_table();
    // RAM write, read and fetch at the base range
    add_entry(PORT_DATA,  OP_WRITE, 1'b0, 32'h0001_0040, 32'hA5A5_1234, 32'h0);
    add_entry(PORT_DATA,  OP_READ,  1'b0, 32'h0001_0040, 32'h0, 32'hA5A5_1234);
    add_entry(PORT_FETCH, OP_READ,  1'b0, 32'h0001_0040, 32'h0, 32'hA5A5_1234);
    // Alias write, base read back, and the reverse
    add_entry(PORT_DATA,  OP_WRITE, 1'b0, 32'hFFFF_C080, 32'h1357_9BDF, 32'h0);
    add_entry(PORT_DATA,  OP_READ,  1'b0, 32'h0001_0080, 32'h0, 32'h1357_9BDF);
    add_entry(PORT_FETCH, OP_READ,  1'b0, 32'h0001_0080, 32'h0, 32'h1357_9BDF);
    add_entry(PORT_DATA,  OP_WRITE, 1'b0, 32'h0001_2344, 32'hCAFE_0001, 32'h0);
    add_entry(PORT_DATA,  OP_READ,  1'b0, 32'hFFFF_E344, 32'h0, 32'hCAFE_0001);
    add_entry(PORT_FETCH, OP_READ,  1'b0, 32'hFFFF_E344, 32'h0, 32'hCAFE_0001);
    // RAM still served while in debug mode
    add_entry(PORT_FETCH, OP_READ,  1'b1, 32'h0001_0040, 32'h0, 32'hA5A5_1234);
    // Debug window reads and a store then load over APB
    add_entry(PORT_FETCH, OP_READ,  1'b1, 32'h0000_0400, 32'h0, 32'h0);
    add_entry(PORT_DATA,  OP_READ,  1'b1, 32'h0000_0FFC, 32'h0, 32'h0);
    add_entry(PORT_DATA,  OP_WRITE, 1'b1, 32'h0000_0800, 32'hDEAD_BEEF, 32'h0);
    add_entry(PORT_DATA,  OP_READ,  1'b1, 32'h0000_0800, 32'h0, 32'h0);
    // Tohost capture
    add_entry(PORT_DATA,  OP_WRITE, 1'b0, `TOHOST_ADDR, 32'h0000_0001, 32'h0000_0001);
    // Fetch and load to the debug window at once
    add_entry(PORT_BOTH,  OP_READ,  1'b1, 32'h0000_0600, 32'h0000_0A04, 32'h0);
  endtask

  initial
  begin : main_sequence
    entry_t      e;
    logic        hit;
    logic [31:0] rd_a;
    logic [31:0] rd_b;
    int          cyc_a;
    int          cyc_b;
    int          xfer_before;
    reset_n       = 1'b0;
    i_debug_mode  = 1'b0;
    i_imem_addr   = '0;
    i_imem_rready = 1'b0;
    i_dmem_addr   = '0;
    i_dmem_rready = 1'b0;
    i_dmem_wvalid = 1'b0;
    i_dmem_wdata  = '0;
    build_table();
    repeat (10) @(negedge clk);
    // Reset values still hold at release
    check_value("o_dbg_psel", 32'(o_dbg_psel), 32'd0);
    check_value("o_dbg_penable", 32'(o_dbg_penable), 32'd0);
    check_value("o_imem_rvalid", 32'(o_imem_rvalid), 32'd0);
    check_value("o_dmem_rvalid", 32'(o_dmem_rvalid), 32'd0);
    check_value("o_dmem_wready", 32'(o_dmem_wready), 32'd0);
    check_value("o_tohost", o_tohost, 32'd0);
    reset_n = 1'b1;
    for (int i = 0; i < stim_q.size(); i++)
    begin
      e = stim_q[i];
      // Idle gap so RAM valid from the last read has drained
      repeat (2) @(negedge clk);
      i_debug_mode = e.dbg;
      hit = e.dbg && (e.addr >= `DBG_AREA_START) && (e.addr <= `DBG_AREA_END);
      if (e.port == PORT_BOTH)
      begin
        xfer_before = xfer_count;
        fork
          read_port(PORT_FETCH, e.addr, rd_a, cyc_a);
          read_port(PORT_DATA, e.wdata, rd_b, cyc_b);
        join
        check_value("o_imem_rdata", rd_a, slave_mem[e.addr[11:2]]);
        check_value("o_dmem_rdata", rd_b, slave_mem[e.wdata[11:2]]);
        check_value("apb_transfer_count", xfer_count - xfer_before, 32'd2);
      end
      else if (e.op == OP_WRITE)
      begin
        write_data(e.addr, e.wdata, hit, cyc_a);
        if (hit)
          check_value("slave_mem", slave_mem[e.addr[11:2]], e.wdata);
        else if (e.addr == `TOHOST_ADDR)
          check_value("o_tohost", o_tohost, e.exp_data);
        else
          check_value("o_dmem_wready_delay", cyc_a, 32'd0);
      end
      else
      begin
        read_port(e.port, e.addr, rd_a, cyc_a);
        if (hit)
          check_value((e.port == PORT_FETCH) ? "o_imem_rdata" : "o_dmem_rdata",
                      rd_a, slave_mem[e.addr[11:2]]);
        else
        begin
          check_value((e.port == PORT_FETCH) ? "o_imem_rdata" : "o_dmem_rdata",
                      rd_a, e.exp_data);
          check_value("ram_read_latency", cyc_a, 32'd1);
        end
      end
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- core_bus_fabric.sv
// ================================================
// Core memory fabric with program RAM, debug APB
// and tohost register
// ================================================
`timescale 1ns/100ps

`include "soc_defines.svh"

module core_bus_fabric
  import soc_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      i_debug_mode,

  // Instruction fetch port
  input  word_t     i_imem_addr,
  input  logic      i_imem_rready,
  output logic      o_imem_rvalid,
  output word_t     o_imem_rdata,

  // Data port
  input  word_t     i_dmem_addr,
  input  logic      i_dmem_rready,
  input  logic      i_dmem_wvalid,
  input  word_t     i_dmem_wdata,
  output logic      o_dmem_rvalid,
  output logic      o_dmem_wready,
  output word_t     o_dmem_rdata,

  // External APB to the debug module
  output dbg_addr_t o_dbg_paddr,
  output logic      o_dbg_psel,
  output logic      o_dbg_penable,
  output logic      o_dbg_pwrite,
  output word_t     o_dbg_pwdata,
  input  logic      i_dbg_pready,
  input  word_t     i_dbg_prdata,

  // Test completion
  output word_t     o_tohost
);

  // Decode results
  logic           imem_in_ram;
  logic           imem_in_debug;
  ram_addr_t      imem_ram_addr;
  logic           dmem_in_ram;
  logic           dmem_in_debug;
  ram_addr_t      dmem_ram_addr;

  // RAM ports
  logic           ram_a_en;
  logic           ram_b_rd;
  logic           ram_b_we;
  word_t          ram_a_data;
  word_t          ram_b_data;
  logic           imem_rvalid_ram;
  logic           dmem_rvalid_ram;

  // Fetch side debug path
  logic           fetch_dbg_req;
  logic           fetch_capture;
  logic           fetch_pending;
  logic           fetch_done;
  dbg_fetch_req_t fetch_req_d;
  dbg_fetch_req_t fetch_req_q;
  word_t          fetch_resp;
  word_t          fetch_dbg_rdata;

  // Data side debug path
  logic           data_dbg_req;
  logic           data_capture;
  logic           data_pending;
  logic           data_done;
  dbg_data_req_t  data_req_d;
  dbg_data_req_t  data_req_q;
  word_t          data_resp;
  word_t          data_dbg_rdata;

  // ================================================
  // Address decode
  // ================================================
  mem_map_decoder imem_decoder_i (
    .i_addr       (i_imem_addr),
    .i_debug_mode (i_debug_mode),
    .o_in_ram     (imem_in_ram),
    .o_in_debug   (imem_in_debug),
    .o_ram_addr   (imem_ram_addr)
  );

  mem_map_decoder dmem_decoder_i (
    .i_addr       (i_dmem_addr),
    .i_debug_mode (i_debug_mode),
    .o_in_ram     (dmem_in_ram),
    .o_in_debug   (dmem_in_debug),
    .o_ram_addr   (dmem_ram_addr)
  );

  // ================================================
  // Program RAM
  // ================================================
  // Debug window wins over RAM
  assign ram_a_en = i_imem_rready && imem_in_ram && !imem_in_debug;
  assign ram_b_rd = i_dmem_rready && dmem_in_ram && !dmem_in_debug;
  assign ram_b_we = i_dmem_wvalid && dmem_in_ram && !dmem_in_debug;

  dual_port_ram ram_i (
    .clk       (clk),
    .i_a_en    (ram_a_en),
    .i_a_addr  (imem_ram_addr),
    .o_a_data  (ram_a_data),
    .i_b_en    (ram_b_rd || ram_b_we),
    .i_b_we    (ram_b_we),
    .i_b_addr  (dmem_ram_addr),
    .i_b_wdata (i_dmem_wdata),
    .o_b_data  (ram_b_data)
  );

  // Read valid follows the RAM's one-cycle latency
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      imem_rvalid_ram <= 1'b0;
      dmem_rvalid_ram <= 1'b0;
    end
    else
    begin
      imem_rvalid_ram <= ram_a_en;
      dmem_rvalid_ram <= ram_b_rd;
    end
  end

  // ================================================
  // Debug requests
  // ================================================
  assign fetch_dbg_req = i_imem_rready && imem_in_debug;
  assign data_dbg_req  = (i_dmem_rready || i_dmem_wvalid) && dmem_in_debug;

  // New request only once the previous one has finished
  assign fetch_capture = fetch_dbg_req && !fetch_pending;
  assign data_capture  = data_dbg_req && !data_pending;

  always_comb
  begin
    fetch_req_d.addr = i_imem_addr[$bits(dbg_addr_t)-1:0];
    data_req_d.addr  = i_dmem_addr[$bits(dbg_addr_t)-1:0];
    data_req_d.write = i_dmem_wvalid;
    data_req_d.wdata = i_dmem_wdata;
  end

  dbg_apb_requester #(
    .req_t (dbg_fetch_req_t)
  ) fetch_requester_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .i_capture (fetch_capture),
    .i_req     (fetch_req_d),
    .i_done    (fetch_done),
    .i_rdata   (i_dbg_prdata),
    .o_pending (fetch_pending),
    .o_req     (fetch_req_q),
    .o_resp    (fetch_resp)
  );

  dbg_apb_requester #(
    .req_t (dbg_data_req_t)
  ) data_requester_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .i_capture (data_capture),
    .i_req     (data_req_d),
    .i_done    (data_done),
    .i_rdata   (i_dbg_prdata),
    .o_pending (data_pending),
    .o_req     (data_req_q),
    .o_resp    (data_resp)
  );

  dbg_apb_arbiter arbiter_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_fetch_pending (fetch_pending),
    .i_fetch_req     (fetch_req_q),
    .i_data_pending  (data_pending),
    .i_data_req      (data_req_q),
    .o_fetch_done    (fetch_done),
    .o_data_done     (data_done),
    .o_dbg_paddr     (o_dbg_paddr),
    .o_dbg_psel      (o_dbg_psel),
    .o_dbg_penable   (o_dbg_penable),
    .o_dbg_pwrite    (o_dbg_pwrite),
    .o_dbg_pwdata    (o_dbg_pwdata),
    .i_dbg_pready    (i_dbg_pready),
    .i_dbg_prdata    (i_dbg_prdata)
  );

  // ================================================
  // Core handshakes and read muxes
  // ================================================
  // Live prdata in the done cycle, held word afterwards
  assign fetch_dbg_rdata = fetch_done ? i_dbg_prdata : fetch_resp;
  assign data_dbg_rdata  = data_done ? i_dbg_prdata : data_resp;

  assign o_imem_rvalid = imem_rvalid_ram || fetch_done;
  assign o_dmem_rvalid = dmem_rvalid_ram || (data_done && !data_req_q.write);

  // RAM stores accept at once, debug stores wait for pready
  assign o_dmem_wready = ram_b_we || (data_done && data_req_q.write);

  assign o_imem_rdata = imem_in_debug ? fetch_dbg_rdata :
                        (imem_in_ram ? ram_a_data : '0);
  assign o_dmem_rdata = dmem_in_debug ? data_dbg_rdata :
                        (dmem_in_ram ? ram_b_data : '0);

  // ================================================
  // Tohost
  // ================================================
  // Captures any write to the address, whatever else it hits
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      o_tohost <= '0;
    end
    else if (i_dmem_wvalid && (i_dmem_addr == `TOHOST_ADDR))
    begin
      o_tohost <= i_dmem_wdata;
    end
  end

endmodule

//--- dbg_apb_arbiter.sv
// ================================================
// Two-requester APB master with alternating grant
// ================================================
`timescale 1ns/100ps

module dbg_apb_arbiter
  import soc_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,

  // Fetch requester
  input  logic           i_fetch_pending,
  input  dbg_fetch_req_t i_fetch_req,

  // Data requester
  input  logic           i_data_pending,
  input  dbg_data_req_t  i_data_req,

  // Completion back to the owner
  output logic           o_fetch_done,
  output logic           o_data_done,

  // External APB master
  output dbg_addr_t      o_dbg_paddr,
  output logic           o_dbg_psel,
  output logic           o_dbg_penable,
  output logic           o_dbg_pwrite,
  output word_t          o_dbg_pwdata,
  input  logic           i_dbg_pready,
  input  word_t          i_dbg_prdata
);

  apb_phase_t state;
  apb_phase_t state_next;

  // Set when the data side owned the last finished transfer
  logic last_grant_data;

  // Owner of the transfer in flight, 1 for data
  logic owner_data;

  logic any_pending;
  logic grant_data;
  logic xfer_done;

  assign any_pending = i_fetch_pending || i_data_pending;

  // On a tie the side not served last wins
  assign grant_data = i_data_pending && (!i_fetch_pending || !last_grant_data);

  // Access phase ends on pready
  assign xfer_done = (state == ACCESS) && i_dbg_pready;

  // ================================================
  // Phase FSM
  // ================================================
  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
        if (any_pending)
          state_next = SETUP;
      SETUP:
        state_next = ACCESS;
      ACCESS:
        if (i_dbg_pready)
          state_next = IDLE;
      default:
        state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state           <= IDLE;
      owner_data      <= 1'b0;
      last_grant_data <= 1'b0;
    end
    else
    begin
      state <= state_next;
      // Owner latched at grant, held through setup and access
      if ((state == IDLE) && any_pending)
      begin
        owner_data <= grant_data;
      end
      if (xfer_done)
      begin
        last_grant_data <= owner_data;
      end
    end
  end

  // ================================================
  // APB outputs
  // ================================================
  assign o_dbg_psel    = (state != IDLE);
  assign o_dbg_penable = (state == ACCESS);

  // Fetch transfers are always reads
  assign o_dbg_paddr  = owner_data ? i_data_req.addr : i_fetch_req.addr;
  assign o_dbg_pwrite = owner_data && i_data_req.write;
  assign o_dbg_pwdata = owner_data ? i_data_req.wdata : '0;

  // Completion routed to whoever owns the bus
  assign o_fetch_done = xfer_done && !owner_data;
  assign o_data_done  = xfer_done && owner_data;

endmodule

//--- dbg_apb_requester.sv
// ================================================
// One-entry debug request holder with response word
// ================================================
`timescale 1ns/100ps

module dbg_apb_requester
  import soc_pkg::*;
#(
  parameter type req_t = dbg_fetch_req_t
) (
  input  logic  clk,
  input  logic  reset_n,

  // From the core side decode
  input  logic  i_capture,
  input  req_t  i_req,

  // From the arbiter
  input  logic  i_done,
  input  word_t i_rdata,

  // To the arbiter
  output logic  o_pending,
  output req_t  o_req,

  // Read data held for the core
  output word_t o_resp
);

  // ================================================
  // Pending flag
  // ================================================
  // Set one cycle after capture, cleared when the transfer ends
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      o_pending <= 1'b0;
    end
    else if (i_done)
    begin
      o_pending <= 1'b0;
    end
    else if (i_capture)
    begin
      o_pending <= 1'b1;
    end
  end

  // ================================================
  // Request and response payload
  // ================================================
  // Request frozen for the whole APB transfer
  always_ff @(posedge clk)
  begin
    if (i_capture)
    begin
      o_req <= i_req;
    end
  end

  // Keep the returned word so read data stays put after the valid pulse
  always_ff @(posedge clk)
  begin
    if (i_done)
    begin
      o_resp <= i_rdata;
    end
  end

endmodule

//--- dual_port_ram.sv
// ================================================
// Behavioral dual-port program RAM
// ================================================
`timescale 1ns/100ps

`include "soc_defines.svh"

module dual_port_ram (
  input  logic               clk,

  // Port A, fetch side, read only
  input  logic               i_a_en,
  input  logic [`RAM_AW-1:0] i_a_addr,
  output logic [`WORD_W-1:0] o_a_data,

  // Port B, data side, read and write
  input  logic               i_b_en,
  input  logic               i_b_we,
  input  logic [`RAM_AW-1:0] i_b_addr,
  input  logic [`WORD_W-1:0] i_b_wdata,
  output logic [`WORD_W-1:0] o_b_data
);

  // Storage array
  logic [`WORD_W-1:0] mem [0:`RAM_DEPTH-1];

  // ================================================
  // Port A
  // ================================================
  // Registered read, data one cycle after enable
  always_ff @(posedge clk)
  begin
    if (i_a_en)
    begin
      o_a_data <= mem[i_a_addr];
    end
  end

  // ================================================
  // Port B
  // ================================================
  // Read-before-write on a shared address
  always_ff @(posedge clk)
  begin
    if (i_b_en)
    begin
      if (i_b_we)
      begin
        mem[i_b_addr] <= i_b_wdata;
      end
      o_b_data <= mem[i_b_addr];
    end
  end

endmodule

//--- mem_map_decoder.sv
// ================================================
// CPU address decode to RAM, alias and debug window
// ================================================
`timescale 1ns/100ps

`include "soc_defines.svh"

module mem_map_decoder
  import soc_pkg::*;
(
  input  word_t     i_addr,
  input  logic      i_debug_mode,
  output logic      o_in_ram,
  output logic      o_in_debug,
  output ram_addr_t o_ram_addr
);

  // Last byte of the RAM range, 0x13FFF
  localparam word_t RAM_END_ADDR = `RAM_BASE_ADDR + (`RAM_DEPTH * 4) - 1;

  logic                    in_base_range;
  logic                    in_alias_range;
  word_t                   rel_addr;
  logic [`RAM_BYTE_AW-1:0] byte_offset;

  // Direct RAM range
  assign in_base_range = (i_addr >= `RAM_BASE_ADDR) && (i_addr <= RAM_END_ADDR);

  // High alias, e.g. 0xFFFFFF10 lands in RAM as well
  assign in_alias_range = (i_addr[$bits(word_t)-1:`RAM_BYTE_AW] == `RAM_ALIAS_PREFIX);

  assign o_in_ram = in_base_range || in_alias_range;

  // Debug window only exists while the core is halted in debug mode
  assign o_in_debug = i_debug_mode &&
                      (i_addr >= `DBG_AREA_START) &&
                      (i_addr <= `DBG_AREA_END);

  // Offset from RAM base for the direct range
  assign rel_addr = i_addr - `RAM_BASE_ADDR;

  // Alias wraps on the low 14 bits
  assign byte_offset = in_alias_range ? i_addr[`RAM_BYTE_AW-1:0]
                                      : rel_addr[`RAM_BYTE_AW-1:0];

  // Drop byte lane bits to get the word index
  assign o_ram_addr = byte_offset[`RAM_BYTE_AW-1:2];

endmodule

//--- soc_pkg.sv
// ================================================
// Shared word, address and debug request types
// ================================================
`include "soc_defines.svh"

package soc_pkg;

  // One bus data word
  typedef logic [`WORD_W-1:0] word_t;

  // Word index into program RAM
  typedef logic [`RAM_AW-1:0] ram_addr_t;

  // Address on the external APB bus
  typedef logic [`DBG_AW-1:0] dbg_addr_t;

  // Instruction fetch over APB, always a read
  typedef struct packed {
    dbg_addr_t addr;
  } dbg_fetch_req_t;

  // Load or store over APB
  typedef struct packed {
    dbg_addr_t addr;
    logic      write;
    word_t     wdata;
  } dbg_data_req_t;

  // APB master phase
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_phase_t;

endpackage

//--- soc_defines.svh
// ================================================
// Memory map and bus width macros for the fabric
// ================================================
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Data path width
`define WORD_W 32

// Program RAM, 16 KB of 32-bit words
`define RAM_BASE_ADDR 32'h0001_0000
`define RAM_DEPTH 4096
`define RAM_AW 12
`define RAM_BYTE_AW 14

// Top 18 address bits of the high alias range
`define RAM_ALIAS_PREFIX 18'h3_FFFF

// Debug module window, reached over APB in debug mode
`define DBG_AREA_START 32'h0000_0200
`define DBG_AREA_END 32'h0000_0FFF
`define DBG_AW 13

// Test completion register
`define TOHOST_ADDR 32'h8000_1000

`endif
